// File: common/debug_pkg.sv
package debug_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0]  byte_t;     // One UART byte
    typedef logic [31:0] word_t;     // Processor word
    typedef logic [4:0]  rb_addr_t;  // Register bank address
    typedef logic [4:0]  dm_addr_t;  // Data memory word address
    typedef logic [7:0]  im_addr_t;  // Instruction memory byte address
    typedef logic [1:0]  byte_idx_t; // 0 is the most significant byte

    // Dump and load sizes
    localparam int RB_DEPTH      = 32;
    localparam int DM_DEPTH      = 32;
    localparam int PROGRAM_BYTES = 68;

    // Command bytes from the host
    localparam byte_t CMD_WRITE_IM     = 8'd1; // Load program
    localparam byte_t CMD_START        = 8'd2; // Free run until halt
    localparam byte_t CMD_STEP_BY_STEP = 8'd3; // Enter step mode
    localparam byte_t CMD_SEND_BR      = 8'd4; // Dump register bank
    localparam byte_t CMD_SEND_MEM     = 8'd5; // Dump data memory
    localparam byte_t CMD_SEND_PC      = 8'd6; // Dump program counter
    localparam byte_t CMD_STEP         = 8'd7; // One step, then full dump
    localparam byte_t CMD_CONTINUE     = 8'd8; // Leave step mode and run

    // Controller states
    typedef enum logic [3:0] {
        IDLE,
        WRITE_IM,
        READY,
        RUN,
        STEP_WAIT,
        SEND_PC,
        READ_MEM,
        SEND_MEM,
        READ_BR,
        SEND_BR
    } dbg_state_t;

    // Source of the word being dumped
    typedef enum logic [1:0] {
        PC,
        MEM,
        BR
    } dump_sel_t;

endpackage

// File: src/dump_counter.sv
module dump_counter (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_clear,
    input  debug_pkg::dump_sel_t i_dump_sel,
    input  logic                 i_word_sent,
    output debug_pkg::rb_addr_t  o_word_addr,
    output logic                 o_last_word
);

    debug_pkg::rb_addr_t word_addr;
    debug_pkg::rb_addr_t last_addr;
    logic                at_last;

    // Final address of the active dump
    always_comb begin
        case (i_dump_sel)
            debug_pkg::MEM: last_addr = debug_pkg::rb_addr_t'(debug_pkg::DM_DEPTH - 1);
            debug_pkg::BR:  last_addr = debug_pkg::rb_addr_t'(debug_pkg::RB_DEPTH - 1);
            default:        last_addr = '0; // PC is a single word
        endcase
    end

    assign at_last = (word_addr == last_addr);

    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            word_addr <= '0;
        end else if (i_word_sent) begin
            // Wrap so a chained dump starts from zero
            if (at_last) begin
                word_addr <= '0;
            end else begin
                word_addr <= word_addr + 1'b1;
            end
        end
    end

    assign o_word_addr = word_addr;
    assign o_last_word = i_word_sent && at_last;

endmodule

// File: src/word_serializer.sv
module word_serializer (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_go,
    input  debug_pkg::dump_sel_t i_dump_sel,
    input  debug_pkg::word_t     i_pc_value,
    input  debug_pkg::word_t     i_dm_data,
    input  debug_pkg::word_t     i_br_data,
    input  logic                 i_tx_done,
    output debug_pkg::byte_t     o_tx_data,
    output logic                 o_tx_start,
    output logic                 o_word_sent
);

    debug_pkg::word_t     selected;
    debug_pkg::word_t     word;
    debug_pkg::byte_idx_t byte_idx;
    logic                 busy;
    logic                 tx_start;
    logic                 word_sent;

    always_comb begin
        case (i_dump_sel)
            debug_pkg::MEM: selected = i_dm_data;
            debug_pkg::BR:  selected = i_br_data;
            default:        selected = i_pc_value;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!busy && i_go) begin
            word <= selected;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            tx_start  <= 1'b0;
            word_sent <= 1'b0;
            byte_idx  <= '0;
        end else begin
            word_sent <= 1'b0;
            if (!busy) begin
                if (i_go) begin
                    busy     <= 1'b1;
                    byte_idx <= '0;
                end
            end else if (tx_start) begin
                if (i_tx_done) begin
                    tx_start <= 1'b0; // One low cycle between bytes
                    if (byte_idx == debug_pkg::byte_idx_t'(3)) begin
                        busy      <= 1'b0;
                        word_sent <= 1'b1;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
            end else begin
                tx_start <= 1'b1;
            end
        end
    end

    // MSB first
    always_comb begin
        case (byte_idx)
            2'd0:    o_tx_data = word[31:24];
            2'd1:    o_tx_data = word[23:16];
            2'd2:    o_tx_data = word[15:8];
            default: o_tx_data = word[7:0];
        endcase
    end

    assign o_tx_start  = tx_start;
    assign o_word_sent = word_sent;

endmodule

// File: src/program_loader.sv
module program_loader (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_active,
    input  logic                i_rx_done,
    input  debug_pkg::byte_t    i_rx_data,
    output logic                o_im_write_enable,
    output debug_pkg::im_addr_t o_im_addr,
    output debug_pkg::byte_t    o_im_data,
    output logic                o_load_last
);

    debug_pkg::im_addr_t count; // Bytes written so far
    logic                write_enable;
    debug_pkg::im_addr_t im_addr;
    debug_pkg::byte_t    im_data;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            write_enable <= 1'b0;
            count        <= '0;
        end else begin
            write_enable <= i_active && i_rx_done; // One strobe per byte
            if (!i_active) begin
                count <= '0;
            end else if (i_rx_done) begin
                count <= count + 1'b1;
            end
        end
    end

    // Address and byte captured with the strobe
    always_ff @(posedge i_clock) begin
        if (i_active && i_rx_done) begin
            im_addr <= count;
            im_data <= i_rx_data;
        end
    end

    assign o_im_write_enable = write_enable;
    assign o_im_addr         = im_addr;
    assign o_im_data         = im_data;
    assign o_load_last       = (count == debug_pkg::im_addr_t'(debug_pkg::PROGRAM_BYTES - 1));

endmodule

// File: src/debug_fsm.sv
module debug_fsm (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_rx_done,
    input  debug_pkg::byte_t     i_rx_data,
    input  logic                 i_hlt,
    input  logic                 i_load_last,
    input  logic                 i_word_sent,
    input  logic                 i_last_word,
    output logic                 o_load_active,
    output debug_pkg::dump_sel_t o_dump_sel,
    output logic                 o_dump_clear,
    output logic                 o_word_go,
    output logic                 o_rb_read_enable,
    output logic                 o_dm_read_enable,
    output logic                 o_run_enable,
    output logic                 o_pipeline_enable,
    output logic                 o_step,
    output logic                 o_step_mode
);

    debug_pkg::dbg_state_t state;
    debug_pkg::dbg_state_t next_state;
    logic                  step_chain; // Set while in step mode, dumps chain PC, MEM, BR
    logic                  step_pulse;
    logic                  word_go;

    always_comb begin
        next_state = state;
        case (state)
            debug_pkg::IDLE: begin
                if (i_rx_done) begin
                    case (i_rx_data)
                        debug_pkg::CMD_WRITE_IM: next_state = debug_pkg::WRITE_IM;
                        debug_pkg::CMD_SEND_PC:  next_state = debug_pkg::SEND_PC;
                        debug_pkg::CMD_SEND_MEM: next_state = debug_pkg::READ_MEM;
                        debug_pkg::CMD_SEND_BR:  next_state = debug_pkg::READ_BR;
                        default:                 next_state = state;
                    endcase
                end
            end
            debug_pkg::WRITE_IM: begin
                if (i_rx_done && i_load_last) begin // Last program byte
                    next_state = debug_pkg::READY;
                end
            end
            debug_pkg::READY: begin
                if (i_rx_done) begin
                    case (i_rx_data)
                        debug_pkg::CMD_START:        next_state = debug_pkg::RUN;
                        debug_pkg::CMD_STEP_BY_STEP: next_state = debug_pkg::STEP_WAIT;
                        default:                     next_state = state;
                    endcase
                end
            end
            debug_pkg::RUN: begin
                if (i_hlt) begin
                    next_state = debug_pkg::IDLE;
                end
            end
            debug_pkg::STEP_WAIT: begin
                if (i_rx_done) begin
                    case (i_rx_data)
                        debug_pkg::CMD_STEP:     next_state = debug_pkg::SEND_PC;
                        debug_pkg::CMD_CONTINUE: next_state = debug_pkg::RUN;
                        default:                 next_state = state;
                    endcase
                end
            end
            debug_pkg::SEND_PC: begin
                if (i_word_sent && i_last_word) begin
                    next_state = step_chain ? debug_pkg::READ_MEM : debug_pkg::IDLE;
                end
            end
            debug_pkg::READ_MEM: next_state = debug_pkg::SEND_MEM; // Address out, data next cycle
            debug_pkg::SEND_MEM: begin
                if (i_word_sent) begin
                    if (i_last_word) begin
                        next_state = step_chain ? debug_pkg::READ_BR : debug_pkg::IDLE;
                    end else begin
                        next_state = debug_pkg::READ_MEM;
                    end
                end
            end
            debug_pkg::READ_BR: next_state = debug_pkg::SEND_BR;
            debug_pkg::SEND_BR: begin
                if (i_word_sent) begin
                    if (i_last_word) begin
                        next_state = step_chain ? debug_pkg::STEP_WAIT : debug_pkg::IDLE;
                    end else begin
                        next_state = debug_pkg::READ_BR;
                    end
                end
            end
            default: next_state = debug_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= debug_pkg::IDLE;
            step_chain <= 1'b0;
            step_pulse <= 1'b0;
            word_go    <= 1'b0;
        end else begin
            state      <= next_state;
            step_pulse <= (state == debug_pkg::STEP_WAIT) && (next_state == debug_pkg::SEND_PC);
            // First cycle of every send state hands a word to the serializer
            word_go    <= (next_state != state) &&
                          (next_state inside {debug_pkg::SEND_PC, debug_pkg::SEND_MEM,
                                              debug_pkg::SEND_BR});
            if (next_state == debug_pkg::STEP_WAIT) begin
                step_chain <= 1'b1;
            end else if (next_state inside {debug_pkg::IDLE, debug_pkg::RUN}) begin
                step_chain <= 1'b0;
            end
        end
    end

    always_comb begin
        case (state)
            debug_pkg::READ_MEM, debug_pkg::SEND_MEM: o_dump_sel = debug_pkg::MEM;
            debug_pkg::READ_BR, debug_pkg::SEND_BR:   o_dump_sel = debug_pkg::BR;
            default:                                  o_dump_sel = debug_pkg::PC;
        endcase
    end

    // Counter held at zero outside of dumps
    assign o_dump_clear = !(state inside {debug_pkg::SEND_PC, debug_pkg::READ_MEM,
                                          debug_pkg::SEND_MEM, debug_pkg::READ_BR,
                                          debug_pkg::SEND_BR});

    assign o_load_active     = (state == debug_pkg::WRITE_IM);
    assign o_word_go         = word_go;
    assign o_rb_read_enable  = state inside {debug_pkg::READ_BR, debug_pkg::SEND_BR};
    assign o_dm_read_enable  = state inside {debug_pkg::READ_MEM, debug_pkg::SEND_MEM};
    assign o_run_enable      = (state == debug_pkg::RUN);
    assign o_pipeline_enable = (state == debug_pkg::RUN) || step_pulse; // Step advances one cycle
    assign o_step            = step_pulse;
    assign o_step_mode       = step_chain;

endmodule

// File: src/debug_unit.sv
module debug_unit (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_rx_done,
    input  debug_pkg::byte_t    i_rx_data,
    input  logic                i_tx_done,
    input  logic                i_hlt,
    input  debug_pkg::word_t    i_pc_value,
    input  debug_pkg::word_t    i_dm_data,
    input  debug_pkg::word_t    i_br_data,
    output debug_pkg::byte_t    o_tx_data,
    output logic                o_tx_start,
    output logic                o_im_write_enable,
    output debug_pkg::im_addr_t o_im_addr,
    output debug_pkg::byte_t    o_im_data,
    output debug_pkg::rb_addr_t o_rb_addr,
    output logic                o_rb_read_enable,
    output debug_pkg::dm_addr_t o_dm_addr,
    output logic                o_dm_read_enable,
    output logic                o_run_enable,
    output logic                o_pipeline_enable,
    output logic                o_step,
    output logic                o_step_mode
);

    logic                 load_active;
    logic                 load_last;
    debug_pkg::dump_sel_t dump_sel;
    logic                 dump_clear;
    logic                 word_go;
    logic                 word_sent;
    logic                 last_word;
    debug_pkg::rb_addr_t  word_addr;

    debug_fsm u_fsm (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_hlt             (i_hlt),
        .i_load_last       (load_last),
        .i_word_sent       (word_sent),
        .i_last_word       (last_word),
        .o_load_active     (load_active),
        .o_dump_sel        (dump_sel),
        .o_dump_clear      (dump_clear),
        .o_word_go         (word_go),
        .o_rb_read_enable  (o_rb_read_enable),
        .o_dm_read_enable  (o_dm_read_enable),
        .o_run_enable      (o_run_enable),
        .o_pipeline_enable (o_pipeline_enable),
        .o_step            (o_step),
        .o_step_mode       (o_step_mode)
    );

    dump_counter u_counter (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_clear     (dump_clear),
        .i_dump_sel  (dump_sel),
        .i_word_sent (word_sent),
        .o_word_addr (word_addr),
        .o_last_word (last_word)
    );

    word_serializer u_serializer (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_go        (word_go),
        .i_dump_sel  (dump_sel),
        .i_pc_value  (i_pc_value),
        .i_dm_data   (i_dm_data),
        .i_br_data   (i_br_data),
        .i_tx_done   (i_tx_done),
        .o_tx_data   (o_tx_data),
        .o_tx_start  (o_tx_start),
        .o_word_sent (word_sent)
    );

    program_loader u_loader (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_active          (load_active),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_load_last       (load_last)
    );

    // One dump address drives both memories
    assign o_rb_addr = word_addr;
    assign o_dm_addr = word_addr;

endmodule

// File: dv/cpu_model.sv
module cpu_model (
    input  logic                i_clock,
    input  logic                i_tx_start,
    input  debug_pkg::rb_addr_t i_rb_addr,
    input  debug_pkg::dm_addr_t i_dm_addr,
    output logic                o_tx_done,
    output debug_pkg::word_t    o_br_data,
    output debug_pkg::word_t    o_dm_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_NS = 10;

    integer seed;
    int     delay; // Cycles from start to done

    // Register bank and data memory contents
    assign o_br_data = 32'hA500_0000 + (debug_pkg::word_t'(i_rb_addr) * 32'd3);
    assign o_dm_data = (debug_pkg::word_t'(i_dm_addr) * 32'h0101_0101) ^ 32'hDEADBEEF;

    // UART transmitter, one byte at a time
    initial begin
        seed      = 17109;
        o_tx_done = 1'b0;
        forever begin
            @(posedge i_clock);
            #STIM_NS;
            if (i_tx_start) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) begin
                    @(posedge i_clock);
                    #STIM_NS;
                end
                o_tx_done = 1'b1;
                @(posedge i_clock);
                #STIM_NS;
                o_tx_done = 1'b0;
            end
        end
    end

endmodule

// File: dv/debug_unit_tb.sv
module debug_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {ACT_CMD, ACT_LOAD, ACT_HALT} action_t;
    typedef enum logic [2:0] {DUMP_NONE, DUMP_PC, DUMP_MEM, DUMP_BR, DUMP_STEP} dump_t;
    typedef enum logic [2:0] {END_NONE, END_LOADED, END_RUN, END_STOPPED, END_STEP_MODE} end_t;

    typedef struct packed {
        action_t          act;
        debug_pkg::byte_t cmd;
        dump_t            dump;
        int               n_bytes;
        end_t             end_chk;
    } entry_t;

    localparam int CLOCK_NS    = 100;
    localparam int STIM_NS     = 10;
    localparam int NUM_ENTRIES = 14;
    // 912 dumped bytes at up to 8 cycles each, two loads, three times over
    localparam int WATCHDOG_NS = (912 * 8 + 2 * 70 * 2) * 3 * CLOCK_NS;

    entry_t tests [NUM_ENTRIES] = '{
        '{ACT_CMD,  debug_pkg::CMD_SEND_PC,      DUMP_PC,   4,   END_NONE},
        '{ACT_CMD,  debug_pkg::CMD_SEND_BR,      DUMP_BR,   128, END_NONE},
        '{ACT_CMD,  debug_pkg::CMD_SEND_MEM,     DUMP_MEM,  128, END_NONE},
        '{ACT_LOAD, debug_pkg::CMD_WRITE_IM,     DUMP_NONE, 0,   END_LOADED},
        '{ACT_CMD,  debug_pkg::CMD_START,        DUMP_NONE, 0,   END_RUN},
        '{ACT_HALT, 8'h00,                       DUMP_NONE, 0,   END_STOPPED},
        '{ACT_CMD,  debug_pkg::CMD_SEND_PC,      DUMP_PC,   4,   END_NONE},
        '{ACT_LOAD, debug_pkg::CMD_WRITE_IM,     DUMP_NONE, 0,   END_LOADED},
        '{ACT_CMD,  debug_pkg::CMD_STEP_BY_STEP, DUMP_NONE, 0,   END_STEP_MODE},
        '{ACT_CMD,  debug_pkg::CMD_STEP,         DUMP_STEP, 260, END_STEP_MODE},
        '{ACT_CMD,  debug_pkg::CMD_STEP,         DUMP_STEP, 260, END_STEP_MODE},
        '{ACT_CMD,  debug_pkg::CMD_CONTINUE,     DUMP_NONE, 0,   END_RUN},
        '{ACT_HALT, 8'h00,                       DUMP_NONE, 0,   END_STOPPED},
        '{ACT_CMD,  debug_pkg::CMD_SEND_MEM,     DUMP_MEM,  128, END_NONE}
    };

    logic i_clock, i_reset, i_rx_done, i_tx_done, i_hlt;
    logic o_tx_start, o_im_write_enable, o_rb_read_enable, o_dm_read_enable;
    logic o_run_enable, o_pipeline_enable, o_step, o_step_mode;
    debug_pkg::byte_t    i_rx_data, o_tx_data, o_im_data;
    debug_pkg::word_t    i_pc_value, i_dm_data, i_br_data;
    debug_pkg::im_addr_t o_im_addr;
    debug_pkg::rb_addr_t o_rb_addr;
    debug_pkg::dm_addr_t o_dm_addr;

    integer           seed;
    int               errors, checks, wr_count, step_count;
    debug_pkg::byte_t tx_bytes[$], exp_bytes[$];
    logic [1:0]       tx_enables[$], exp_enables[$]; // {dm, rb} read enables per byte

    debug_unit dut0 (.*);

    cpu_model cpu0 (
        .i_clock    (i_clock),
        .i_tx_start (o_tx_start),
        .i_rb_addr  (o_rb_addr),
        .i_dm_addr  (o_dm_addr),
        .o_tx_done  (i_tx_done),
        .o_br_data  (i_br_data),
        .o_dm_data  (i_dm_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLOCK_NS / 2) i_clock = ~i_clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the test sequence finished", $time);
        $display("Verification failed");
        $finish;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic debug_pkg::word_t reg_word(input int addr);
        return 32'hA500_0000 + debug_pkg::word_t'(3 * addr);
    endfunction

    function automatic debug_pkg::word_t mem_word(input int addr);
        return (debug_pkg::word_t'(addr) * 32'h0101_0101) ^ 32'hDEADBEEF;
    endfunction

    task automatic add_word(input debug_pkg::word_t w, input logic [1:0] enables);
        for (int b = 3; b >= 0; b--) begin // MSB first
            exp_bytes.push_back(w[b * 8 +: 8]);
            exp_enables.push_back(enables);
        end
    endtask

    task automatic build_expected(input dump_t dump);
        exp_bytes.delete();
        exp_enables.delete();
        if (dump == DUMP_PC || dump == DUMP_STEP) begin
            add_word(i_pc_value, 2'b00);
        end
        for (int a = 0; a < debug_pkg::DM_DEPTH && dump inside {DUMP_MEM, DUMP_STEP}; a++) begin
            add_word(mem_word(a), 2'b10);
        end
        for (int a = 0; a < debug_pkg::RB_DEPTH && dump inside {DUMP_BR, DUMP_STEP}; a++) begin
            add_word(reg_word(a), 2'b01);
        end
    endtask

    task automatic send_byte(input debug_pkg::byte_t b);
        @(posedge i_clock);
        #STIM_NS;
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(posedge i_clock);
        #STIM_NS;
        i_rx_done = 1'b0;
    endtask

    // Sampled mid-cycle, away from both edges
    always @(negedge i_clock) begin
        if (o_tx_start && i_tx_done) begin
            tx_bytes.push_back(o_tx_data);
            tx_enables.push_back({o_dm_read_enable, o_rb_read_enable});
        end
        if (o_step) begin
            step_count++;
        end
        if (o_im_write_enable) begin
            checks++;
            if (o_im_addr != debug_pkg::im_addr_t'(wr_count) ||
                o_im_data != (debug_pkg::byte_t'(wr_count) ^ 8'h5A)) begin
                report_error($sformatf("IM write %0d got addr %0d data %h",
                                       wr_count, o_im_addr, o_im_data));
            end
            wr_count++;
        end
    end

    task automatic run_entry(input int idx);
        entry_t e;
        int     waited;
        logic   mismatch;
        e        = tests[idx];
        waited   = 0;
        mismatch = 1'b0;
        @(posedge i_clock);
        #STIM_NS;
        tx_bytes.delete();
        tx_enables.delete();
        step_count = 0;
        i_pc_value = $random(seed);
        build_expected(e.dump);
        if (e.act == ACT_LOAD) begin
            wr_count = 0;
            send_byte(e.cmd);
            for (int k = 0; k < debug_pkg::PROGRAM_BYTES; k++) begin
                send_byte(debug_pkg::byte_t'(k) ^ 8'h5A);
            end
        end else if (e.act == ACT_HALT) begin
            i_hlt = 1'b1;
        end else begin
            send_byte(e.cmd);
        end
        while (tx_bytes.size() < e.n_bytes && waited < e.n_bytes * 8 + 50) begin
            @(posedge i_clock);
            waited++;
        end
        if (tx_bytes.size() < e.n_bytes) begin
            errors++;
            $display("Entry %0d timed out with %0d of %0d bytes sent",
                     idx, tx_bytes.size(), e.n_bytes);
        end
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        checks++;
        if ((e.end_chk == END_LOADED && wr_count != debug_pkg::PROGRAM_BYTES) ||
            (e.end_chk == END_RUN && (!o_run_enable || !o_pipeline_enable || o_step_mode)) ||
            (e.end_chk == END_STOPPED && (o_run_enable || o_pipeline_enable)) ||
            (e.end_chk == END_STEP_MODE && (!o_step_mode || o_run_enable))) begin
            report_error($sformatf("entry %0d wrong end state, writes %0d run %b pipe %b mode %b",
                                   idx, wr_count, o_run_enable, o_pipeline_enable, o_step_mode));
        end
        @(posedge i_clock);
        #STIM_NS;
        i_hlt = 1'b0;
        repeat (6) @(posedge i_clock); // Catch any extra byte
        checks++;
        if (tx_bytes.size() != e.n_bytes || step_count != ((e.dump == DUMP_STEP) ? 1 : 0)) begin
            report_error($sformatf("entry %0d sent %0d bytes, expected %0d, step pulses %0d",
                                   idx, tx_bytes.size(), e.n_bytes, step_count));
        end
        for (int k = 0; k < tx_bytes.size() && k < exp_bytes.size() && !mismatch; k++) begin
            checks++;
            if (tx_bytes[k] != exp_bytes[k] || tx_enables[k] != exp_enables[k]) begin
                mismatch = 1'b1;
                report_error($sformatf("entry %0d byte %0d got %h en %b, expected %h en %b",
                                       idx, k, tx_bytes[k], tx_enables[k],
                                       exp_bytes[k], exp_enables[k]));
            end
        end
    endtask

    initial begin
        seed       = 17109;
        errors     = 0;
        checks     = 0;
        wr_count   = 0;
        step_count = 0;
        i_reset    = 1'b1;
        i_rx_done  = 1'b0;
        i_rx_data  = '0;
        i_hlt      = 1'b0;
        i_pc_value = '0;
        repeat (2) @(posedge i_clock);
        #STIM_NS;
        i_reset = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
common/debug_pkg.sv
src/dump_counter.sv
src/word_serializer.sv
src/program_loader.sv
src/debug_fsm.sv
src/debug_unit.sv
dv/cpu_model.sv
dv/debug_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module debug_unit_tb -f filelist.f -o debug_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/debug_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
